/* logic/mult_control.sv */
module mult_control
    import mult_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,

    input  logic       start,
    input  logic       step_last,

    output mult_ctrl_t ctrl,
    output logic       busy,
    output logic       done
);

    mult_state_t state_q;
    mult_state_t state_d;
    logic        accept;

    // start only counts when not running
    always_comb begin
        case (state_q)
            IDLE:    accept = start;
            DONE:    accept = start;
            default: accept = 1'b0;
        endcase
    end

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                // counter at 15 means this is the sign bit step
                if (step_last) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                if (accept) begin
                    state_d = RUN;
                end else begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // outputs
    always_comb begin
        ctrl           = '0;
        busy           = 1'b0;
        done           = 1'b0;
        ctrl.load      = accept;
        ctrl.clear     = accept;
        case (state_q)
            RUN: begin
                busy           = 1'b1;
                ctrl.step      = 1'b1;
                ctrl.last_step = step_last;
            end
            DONE: begin
                done = 1'b1;
            end
            default: begin
                busy = 1'b0;
            end
        endcase
    end

endmodule

/* logic/mult_datapath.sv */
module mult_datapath
    import mult_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,

    input  mult_ctrl_t ctrl,

    input  operand_t   multiplicand,
    input  operand_t   multiplier,

    output logic       step_last,
    output product_t   product
);

    operand_t mcand_q;
    product_t mcand_ext;
    product_t partial;
    product_t partial_signed;
    product_t partial_shifted;
    product_t acc_q;
    product_t acc_d;
    step_t    count_q;
    step_t    count_d;
    logic     scan_bit;

    // multiplicand holds for the whole operation
    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            mcand_q <= multiplicand;
        end
    end

    // multiplier bits, lsb first
    multiplier_scan scan0 (
        .clk      (clk),
        .n_rst    (n_rst),
        .load     (ctrl.load),
        .shift    (ctrl.step),
        .value    (multiplier),
        .scan_bit (scan_bit)
    );

    // sign extend to product width
    assign mcand_ext = product_t'(mcand_q);

    // select multiplicand or zero
    always_comb begin
        if (ctrl.step && scan_bit) begin
            partial = mcand_ext;
        end else begin
            partial = '0;
        end
    end

    // the sign bit weighs -2^15, so subtract on the last step
    always_comb begin
        if (ctrl.last_step) begin
            partial_signed = -partial;
        end else begin
            partial_signed = partial;
        end
    end

    // weight by bit position
    assign partial_shifted = partial_signed <<< count_q;

    // counter and accumulator next values
    always_comb begin
        count_d = count_q;
        acc_d   = acc_q;
        if (ctrl.clear) begin
            count_d = '0;
            acc_d   = '0;
        end else if (ctrl.step) begin
            count_d = count_q + step_t'(1);
            acc_d   = acc_q + partial_shifted;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            count_q <= '0;
            acc_q   <= '0;
        end else begin
            count_q <= count_d;
            acc_q   <= acc_d;
        end
    end

    // counter at its final value
    assign step_last = (count_q == step_t'(STEP_COUNT - 1));

    // holds after done until next clear
    assign product = acc_q;

endmodule

/* logic/mult_pkg.sv */
package mult_pkg;

    // operand and result widths
    localparam int OP_WIDTH   = 16;
    localparam int PROD_WIDTH = 32;

    // one accumulate step per multiplier bit
    localparam int STEP_COUNT = 16;
    localparam int STEP_WIDTH = $clog2(STEP_COUNT);

    // two's-complement operands
    typedef logic signed [OP_WIDTH-1:0] operand_t;

    // accumulator and final product
    typedef logic signed [PROD_WIDTH-1:0] product_t;

    // step counter, 0 to 15
    typedef logic [STEP_WIDTH-1:0] step_t;

    // controller to datapath
    typedef struct packed {
        // capture both operands
        logic load;
        // zero accumulator and counter
        logic clear;
        // add partial product, advance counter
        logic step;
        // sign bit of multiplier, subtract instead of add
        logic last_step;
    } mult_ctrl_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        RUN  = 2'b01,
        DONE = 2'b10
    } mult_state_t;

endpackage

/* logic/multiplier_scan.sv */
module multiplier_scan
    import mult_pkg::*;
(
    input  logic     clk,
    input  logic     n_rst,

    input  logic     load,
    input  logic     shift,
    input  operand_t value,

    output logic     scan_bit
);

    operand_t scan_q;
    operand_t scan_d;

    // load wins over shift
    always_comb begin
        if (load) begin
            scan_d = value;
        end else if (shift) begin
            scan_d = {1'b0, scan_q[OP_WIDTH-1:1]};
        end else begin
            scan_d = scan_q;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            scan_q <= '0;
        end else begin
            scan_q <= scan_d;
        end
    end

    // bit for the step about to run
    assign scan_bit = scan_q[0];

endmodule

/* logic/shift_add_mult.sv */
module shift_add_mult
    import mult_pkg::*;
(
    input  logic     clk,
    input  logic     n_rst,
    input  logic     start,

    input  operand_t multiplicand,
    input  operand_t multiplier,

    output logic     busy,
    output logic     done,
    output product_t product
);

    mult_ctrl_t ctrl;
    logic       step_last;

    // sequencing
    mult_control control0 (
        .clk       (clk),
        .n_rst     (n_rst),
        .start     (start),
        .step_last (step_last),
        .ctrl      (ctrl),
        .busy      (busy),
        .done      (done)
    );

    // operands, scan and accumulator
    mult_datapath datapath0 (
        .clk          (clk),
        .n_rst        (n_rst),
        .ctrl         (ctrl),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .step_last    (step_last),
        .product      (product)
    );

endmodule

/* project.f */
logic/mult_pkg.sv
logic/multiplier_scan.sv
logic/mult_datapath.sv
logic/mult_control.sv
logic/shift_add_mult.sv
verif/mult_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

rm -rf "$build_dir" "$log_file"

verilator --binary --timing --assert \
    --top-module mult_tb \
    --Mdir "$build_dir" \
    -o mult_sim \
    -f project.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/mult_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"

# the log decides the result
if grep -q "Regression failed" "$log_file"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "Regression passed" "$log_file"; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"
exit 0

/* verif/mult_tb.sv */
module mult_tb
    import mult_pkg::*;
();

    logic     clk;
    logic     n_rst;
    logic     start;
    operand_t multiplicand;
    operand_t multiplier;
    logic     busy;
    logic     done;
    product_t product;

    // reference timing model
    logic [4:0] run_left;
    logic       exp_done;
    logic       exp_busy;
    product_t   exp_product;

    string test_name;
    int    seed;

    shift_add_mult dut0 (
        .clk          (clk),
        .n_rst        (n_rst),
        .start        (start),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .busy         (busy),
        .done         (done),
        .product      (product)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // plain signed multiply on widened operands
    function automatic product_t ref_product(input operand_t a, input operand_t b);
        return product_t'(a) * product_t'(b);
    endfunction

    function automatic operand_t random_operand();
        return operand_t'($random(seed));
    endfunction

    // start only taken when no operation is running
    always @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            run_left    <= 5'd0;
            exp_done    <= 1'b0;
            exp_product <= '0;
        end else if (start && run_left == 5'd0) begin
            run_left    <= 5'(STEP_COUNT);
            exp_done    <= 1'b0;
            exp_product <= ref_product(multiplicand, multiplier);
        end else if (run_left != 5'd0) begin
            run_left <= run_left - 5'd1;
            exp_done <= (run_left == 5'd1);
        end else begin
            exp_done <= 1'b0;
        end
    end

    assign exp_busy = (run_left != 5'd0);

    task automatic value_mismatch(input string check, input longint expected,
                                  input longint actual);
        $display("ERROR %s (%s): expected %0d, actual %0d",
                 test_name, check, expected, actual);
        $display("Regression failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic done_timeout();
        $display("%s: done never arrived within 40 cycles", test_name);
        $display("Regression failed");
        $fatal(1, "timeout while waiting for done");
    endtask

    busy_check: assert property (@(posedge clk) disable iff (!n_rst) busy == exp_busy)
        else value_mismatch("busy", longint'($sampled(exp_busy)), longint'($sampled(busy)));

    done_check: assert property (@(posedge clk) disable iff (!n_rst) done == exp_done)
        else value_mismatch("done", longint'($sampled(exp_done)), longint'($sampled(done)));

    product_at_done: assert property (@(posedge clk) disable iff (!n_rst)
        done |-> product == exp_product)
        else value_mismatch("product at done", longint'($sampled(exp_product)),
                            longint'($sampled(product)));

    // also covers the zero product right after reset
    product_held: assert property (@(posedge clk) disable iff (!n_rst)
        !exp_busy |-> product == exp_product)
        else value_mismatch("product while idle", longint'($sampled(exp_product)),
                            longint'($sampled(product)));

    // start is sampled on the edge after the call
    task automatic start_op(input operand_t a, input operand_t b);
        start        = 1'b1;
        multiplicand = a;
        multiplier   = b;
        @(posedge clk);
        #1;
        start        = 1'b0;
        // operands must not matter once captured
        multiplicand = random_operand();
        multiplier   = random_operand();
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (!done) begin
            if (cycles == 40) begin
                done_timeout();
            end else begin
                @(posedge clk);
                #1;
                cycles = cycles + 1;
            end
        end
    endtask

    task automatic run_op(input string name, input operand_t a, input operand_t b);
        test_name = name;
        start_op(a, b);
        wait_for_done();
        @(posedge clk);
        #1;
    endtask

    initial begin
        int i;

        n_rst        = 1'b0;
        start        = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        seed         = 32'h41e5_14cb;
        test_name    = "reset";

        repeat (4) @(posedge clk);
        #1;
        n_rst = 1'b1;

        // idle, nothing started yet
        repeat (3) begin
            @(posedge clk);
            #1;
        end

        run_op("zero times x", 16'sd0, -16'sd12345);
        run_op("x times zero", 16'sd9876, 16'sd0);
        run_op("one times minus one", 16'sd1, 16'shffff);
        run_op("minus one squared", 16'shffff, 16'shffff);
        run_op("max squared", 16'sh7fff, 16'sh7fff);
        run_op("min times max", 16'sh8000, 16'sh7fff);
        run_op("min squared", 16'sh8000, 16'sh8000);

        for (i = 0; i < 200; i = i + 1) begin
            run_op($sformatf("random %0d", i), random_operand(), random_operand());
        end

        test_name = "start while busy";
        start_op(16'sd1234, -16'sd321);
        repeat (5) begin
            @(posedge clk);
            #1;
        end
        start        = 1'b1;
        multiplicand = 16'sh7fff;
        multiplier   = 16'sh8000;
        @(posedge clk);
        #1;
        start = 1'b0;
        wait_for_done();
        @(posedge clk);
        #1;

        test_name = "back to back";
        start_op(-16'sd300, 16'sd77);
        wait_for_done();
        // new start lands in the done cycle
        start_op(16'sd4096, -16'sd8);
        wait_for_done();
        for (i = 0; i < 20; i = i + 1) begin
            // previous result is checked on the accepting edge
            start_op(random_operand(), random_operand());
            test_name = $sformatf("back to back random %0d", i);
            wait_for_done();
        end
        @(posedge clk);
        #1;

        test_name = "hold while idle";
        repeat (6) begin
            @(posedge clk);
            #1;
        end

        $display("Regression passed");
        $finish;
    end

endmodule
